/* src/game_pkg.sv */
// game package
// shared types for the game side: FSM states, stage index,
// conditioned inputs, enemy choice and block control lines
`default_nettype none

package game_pkg;

    // top level game FSM states
    typedef enum logic [2:0] {
        ST_RESET     = 3'd0,
        ST_RUN       = 3'd1,
        ST_PAUSE     = 3'd2,
        ST_STAGE_WON = 3'd3,
        ST_GAME_OVER = 3'd4
    } game_state_t;

    typedef logic [2:0] stage_t; // up to 8 stages per game

    // synchronized board and status inputs
    typedef struct packed {
        logic start;
        logic pause;
        logic win;
        logic dead;
        logic skip_pulse; // one cycle per button press
    } ctrl_in_t;

    // enemy type active in the current stage
    typedef struct packed {
        logic monst;
        logic astero;
        logic boss;
    } enemy_sel_t;

    // enables and resets towards the object engines
    typedef struct packed {
        logic en_player;
        logic en_monst;
        logic en_astero;
        logic en_boss;
        logic rst_player_n; // active low
        logic rst_monst_n;  // active low
    } block_ctrl_t;

endpackage

`default_nettype wire

/* src/wb_pkg.sv */
// Wishbone package
// classic bus request and response structs plus the
// register map of the game status slave
`default_nettype none

package wb_pkg;

    // host to slave, held until ack
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to host
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // word addresses
    typedef enum logic [1:0] {
        REG_STATUS = 2'd0,
        REG_SKIP   = 2'd1,
        REG_ID     = 2'd2
    } wb_reg_t;

    localparam logic [31:0] WB_ID_VALUE = 32'h6A43_0102; // returned by REG_ID

endpackage

`default_nettype wire

/* src/input_conditioner.sv */
// input conditioner
// brings the switches and status lines into the clk domain and
// turns the skip button into a single cycle pulse
`timescale 1ns/1ps
`default_nettype none

module input_conditioner #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                resetN,
    input  logic                start_game,
    input  logic                pause,
    input  logic                skip_btn,
    input  logic                win_stage,
    input  logic                player_dead,
    output game_pkg::ctrl_in_t  cond
);

    import game_pkg::*;

    logic [4:0] raw;                      // start, pause, win, dead, skip
    logic [4:0] sync_q [SYNC_STAGES];     // metastability chain
    logic [4:0] sync_out;
    logic       skip_prev;                // last synchronized skip level

    assign raw = {start_game, pause, win_stage, player_dead, skip_btn};

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            skip_prev <= 1'b0;
        end else begin
            sync_q[0] <= raw;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            skip_prev <= sync_out[0];
        end
    end

    assign sync_out = sync_q[SYNC_STAGES-1];

    assign cond.start      = sync_out[4];
    assign cond.pause      = sync_out[3];
    assign cond.win        = sync_out[2];
    assign cond.dead       = sync_out[1];
    assign cond.skip_pulse = sync_out[0] & ~skip_prev; // rising edge only

endmodule

`default_nettype wire

/* src/stage_controller.sv */
// stage controller
// counts cleared stages, picks the enemy type for each stage and
// flags the game as won after the last stage
`timescale 1ns/1ps
`default_nettype none

module stage_controller #(
    parameter int NUM_STAGES = 6
) (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  stage_clear,
    input  logic                  stage_advance,
    output game_pkg::stage_t      stage_num,
    output game_pkg::enemy_sel_t  enemy_sel,
    output logic                  game_won
);

    import game_pkg::*;

    localparam stage_t LAST_STAGE = stage_t'(NUM_STAGES - 1);

    stage_t     stage_q;
    logic       won_q;
    logic [1:0] stage_mod;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            stage_q <= '0;
            won_q   <= 1'b0;
        end else if (stage_clear) begin
            stage_q <= '0;
            won_q   <= 1'b0;
        end else if (stage_advance) begin
            if (stage_q == LAST_STAGE) begin
                won_q <= 1'b1;               // stage stays on the last one
            end else begin
                stage_q <= stage_q + 3'd1;
            end
        end
    end

    assign stage_mod = 2'(stage_q % 3);

    // enemy rotation: monsters, asteroids, boss
    always_comb begin
        enemy_sel = '0;
        if (!won_q) begin
            case (stage_mod)
                2'd0:    enemy_sel.monst  = 1'b1;
                2'd1:    enemy_sel.astero = 1'b1;
                default: enemy_sel.boss   = 1'b1;
            endcase
        end
    end

    assign stage_num = stage_q;
    assign game_won  = won_q;

endmodule

`default_nettype wire

/* src/game_controller.sv */
// game controller
// top level game FSM: reset, run, pause, stage won and game over.
// gates the engine enables and resets and drives the stage sequencer
`timescale 1ns/1ps
`default_nettype none

module game_controller #(
    parameter int NUM_STAGES = 6
) (
    input  logic                   clk,
    input  logic                   resetN,
    input  game_pkg::ctrl_in_t     cond,
    input  logic                   sw_skip,
    output game_pkg::game_state_t  state,
    output game_pkg::block_ctrl_t  blocks,
    output game_pkg::stage_t       stage_num,
    output logic                   game_won,
    output logic                   game_over
);

    import game_pkg::*;

    game_state_t state_q;
    game_state_t state_d;
    enemy_sel_t  enemy_sel;
    logic        stage_clear;
    logic        stage_advance;
    logic        active;        // engines running this cycle

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state_q <= ST_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RESET: begin
                if (cond.start) state_d = ST_RUN;
            end
            ST_RUN: begin
                if (cond.pause) begin
                    state_d = ST_PAUSE;
                end else if (cond.dead) begin
                    state_d = ST_GAME_OVER;
                end else if (cond.win || cond.skip_pulse || sw_skip) begin
                    state_d = ST_STAGE_WON;
                end
            end
            ST_PAUSE: begin
                if (!cond.pause) state_d = ST_RUN;
            end
            ST_STAGE_WON: begin
                state_d = game_won ? ST_GAME_OVER : ST_RUN; // single cycle
            end
            ST_GAME_OVER: begin
                state_d = ST_GAME_OVER;   // wait for start to drop
            end
            default: state_d = ST_RESET;
        endcase
        // dropping the start switch always wins
        if (!cond.start) state_d = ST_RESET;
    end

    assign stage_clear   = (state_q == ST_RESET);
    assign stage_advance = (state_q == ST_RUN) && (state_d == ST_STAGE_WON);

    stage_controller #(
        .NUM_STAGES (NUM_STAGES)
    ) u_stage (
        .clk           (clk),
        .resetN        (resetN),
        .stage_clear   (stage_clear),
        .stage_advance (stage_advance),
        .stage_num     (stage_num),
        .enemy_sel     (enemy_sel),
        .game_won      (game_won)
    );

    assign active = (state_q == ST_RUN) || (state_q == ST_STAGE_WON);

    always_comb begin
        blocks.en_player    = active;
        blocks.en_monst     = active & enemy_sel.monst;
        blocks.en_astero    = active & enemy_sel.astero;
        blocks.en_boss      = active & enemy_sel.boss;
        blocks.rst_player_n = (state_q != ST_RESET);
        // monsters restart on every new stage and stay held when unused
        blocks.rst_monst_n  = enemy_sel.monst &&
                              (state_q != ST_RESET) &&
                              (state_q != ST_STAGE_WON) &&
                              (state_q != ST_GAME_OVER);
    end

    assign game_over = (state_q == ST_GAME_OVER) && !game_won;
    assign state     = state_q;

endmodule

`default_nettype wire

/* src/game_status_wb.sv */
// game status Wishbone slave
// classic cycle slave: status word readback, id register and a
// self clearing stage skip command
`timescale 1ns/1ps
`default_nettype none

module game_status_wb (
    input  logic                   clk,
    input  logic                   resetN,
    input  wb_pkg::wb_req_t        wb_in,
    output wb_pkg::wb_rsp_t        wb_out,
    input  game_pkg::game_state_t  state,
    input  game_pkg::stage_t       stage_num,
    input  logic                   game_won,
    input  logic                   game_over,
    output logic                   sw_skip
);

    import game_pkg::*;
    import wb_pkg::*;

    logic        ack_q;
    logic [31:0] rd_dat;
    logic [31:0] status_word;
    logic        req_new;       // first sampled cycle of a transfer
    wb_reg_t     reg_sel;
    logic        skip_q;

    assign req_new = wb_in.cyc & wb_in.stb & ~ack_q;
    assign reg_sel = wb_reg_t'(wb_in.adr);

    assign status_word = {22'd0, game_over, game_won, 1'b0, stage_num, 1'b0, state};

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ack_q  <= 1'b0;
            skip_q <= 1'b0;
        end else begin
            ack_q  <= req_new;    // one cycle ack
            skip_q <= req_new && wb_in.we && (reg_sel == REG_SKIP) && wb_in.dat[0];
        end
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (req_new && !wb_in.we) begin
            case (reg_sel)
                REG_STATUS: rd_dat <= status_word;
                REG_ID:     rd_dat <= WB_ID_VALUE;
                default:    rd_dat <= '0;
            endcase
        end
    end

    assign wb_out.ack = ack_q;
    assign wb_out.dat = rd_dat;
    assign sw_skip    = skip_q;

endmodule

`default_nettype wire

/* src/game_ctrl_top.sv */
// game control top level
// input conditioning, game FSM with stage sequencer, and the
// Wishbone status slave wired together
`timescale 1ns/1ps
`default_nettype none

module game_ctrl_top #(
    parameter int NUM_STAGES  = 6,
    parameter int SYNC_STAGES = 2
) (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   start_game,
    input  logic                   pause,
    input  logic                   skip_btn,
    input  logic                   win_stage,
    input  logic                   player_dead,
    input  wb_pkg::wb_req_t        wb_in,
    output wb_pkg::wb_rsp_t        wb_out,
    output game_pkg::block_ctrl_t  blocks,
    output logic                   game_won,
    output logic                   game_over,
    output game_pkg::stage_t       stage_num
);

    import game_pkg::*;

    ctrl_in_t    cond;
    game_state_t state;
    logic        sw_skip;     // host requested skip

    input_conditioner #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_in (
        .clk         (clk),
        .resetN      (resetN),
        .start_game  (start_game),
        .pause       (pause),
        .skip_btn    (skip_btn),
        .win_stage   (win_stage),
        .player_dead (player_dead),
        .cond        (cond)
    );

    game_controller #(
        .NUM_STAGES (NUM_STAGES)
    ) u_game (
        .clk       (clk),
        .resetN    (resetN),
        .cond      (cond),
        .sw_skip   (sw_skip),
        .state     (state),
        .blocks    (blocks),
        .stage_num (stage_num),
        .game_won  (game_won),
        .game_over (game_over)
    );

    game_status_wb u_wb (
        .clk       (clk),
        .resetN    (resetN),
        .wb_in     (wb_in),
        .wb_out    (wb_out),
        .state     (state),
        .stage_num (stage_num),
        .game_won  (game_won),
        .game_over (game_over),
        .sw_skip   (sw_skip)
    );

endmodule

`default_nettype wire

/* sim/game_ctrl_chk.sv */
// game control checker
// concurrent properties on the Wishbone ack, the end of game flags
// and the engine enables, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module game_ctrl_chk (
    input logic                  clk,
    input logic                  resetN,
    input wb_pkg::wb_rsp_t       wb_out,
    input game_pkg::block_ctrl_t blocks,
    input game_pkg::game_state_t state,
    input logic                  game_won,
    input logic                  game_over
);

    import game_pkg::*;

    logic [3:0] enables;

    assign enables = {blocks.en_player, blocks.en_monst, blocks.en_astero, blocks.en_boss};

    ack_single: assert property (@(posedge clk) disable iff (!resetN)
        wb_out.ack |=> !wb_out.ack)
        else $error("Wishbone ack held for two cycles");

    won_or_over: assert property (@(posedge clk) disable iff (!resetN)
        !(game_won && game_over))
        else $error("game_won and game_over high together");

    pause_idle: assert property (@(posedge clk) disable iff (!resetN)
        (state == ST_PAUSE) |-> (enables == 4'b0000))
        else $error("engine enabled while paused");

    reset_idle: assert property (@(posedge clk)
        !resetN |-> (enables == 4'b0000))
        else $error("engine enabled during reset");

endmodule

bind game_ctrl_top game_ctrl_chk u_chk (
    .clk       (clk),
    .resetN    (resetN),
    .wb_out    (wb_out),
    .blocks    (blocks),
    .state     (state),   // internal FSM state of the top level
    .game_won  (game_won),
    .game_over (game_over)
);

`default_nettype wire

/* sim/tb_game_ctrl.sv */
// game control testbench
// walks the game FSM through a table of pin and bus steps and checks
// status readback, block controls and flags after each step
`timescale 1ns/1ps
`default_nettype none

module tb_game_ctrl;

    import game_pkg::*;
    import wb_pkg::*;

    typedef struct {
        string       name;
        logic [2:0]  levels;     // start, pause, dead
        logic [1:0]  pulses;     // win, skip one cycle pulses
        logic        host_skip;  // REG_SKIP write
        game_state_t exp_state;
        stage_t      exp_stage;
        logic [3:0]  exp_en;     // player, monst, astero, boss
        logic [1:0]  exp_rst;    // rst_player_n, rst_monst_n
        logic [1:0]  exp_flags;  // game_won, game_over
    } step_t;

    logic clk, resetN, start_game, pause, skip_btn, win_stage, player_dead;
    wb_req_t     wb_in;
    wb_rsp_t     wb_out;
    block_ctrl_t blocks;
    logic        game_won, game_over;
    stage_t      stage_num;
    step_t       steps[$];
    int          errors = 0;
    int          checks = 0;
    int          timeouts = 0;
    int          cycle_count = 0;  // rising edges since time zero
    logic [31:0] rd;

    game_ctrl_top #(.NUM_STAGES(4), .SYNC_STAGES(2)) uut (
        .clk(clk), .resetN(resetN), .start_game(start_game), .pause(pause),
        .skip_btn(skip_btn), .win_stage(win_stage), .player_dead(player_dead),
        .wb_in(wb_in), .wb_out(wb_out), .blocks(blocks), .game_won(game_won),
        .game_over(game_over), .stage_num(stage_num)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic bus_xfer(input logic we, input logic [1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
        int   cycles;
        logic got_ack;
        @(negedge clk);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        cycles  = 0;
        got_ack = 1'b0;
        while (!got_ack && cycles < 10) begin
            @(negedge clk);
            cycles++;
            got_ack = wb_out.ack;
        end
        rdat  = wb_out.dat;
        wb_in = '0;                   // host drops stb after ack
        if (!got_ack) begin
            $display("no Wishbone ack within 10 cycles at address %0d", adr);
            timeouts++;
        end
    endtask

    // poll status until state and stage both match
    task automatic wait_for_status(input string name, input logic [31:0] exp_word);
        int   start_cycle;
        logic found;
        start_cycle = cycle_count;
        found       = 1'b0;
        while (!found && (cycle_count - start_cycle) < 50) begin
            bus_xfer(1'b0, REG_STATUS, '0, rd);
            found = (rd[2:0] == exp_word[2:0]) && (rd[6:4] == exp_word[6:4]);
        end
        if (!found) begin
            $display("%s: status never reached the expected state and stage in 50 cycles",
                     name);
            timeouts++;
        end
        check_value({name, " status"}, exp_word, rd);
    endtask

    task automatic add_step(input string name, input logic [2:0] levels,
                            input logic [1:0] pulses, input logic host_skip,
                            input game_state_t st, input stage_t stage,
                            input logic [3:0] en, input logic [1:0] rst,
                            input logic [1:0] flags);
        steps.push_back('{name, levels, pulses, host_skip, st, stage, en, rst, flags});
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] exp_word;
        @(negedge clk);
        {start_game, pause, player_dead} = s.levels;
        {win_stage, skip_btn} = s.pulses;
        @(negedge clk);
        win_stage = 1'b0;
        skip_btn  = 1'b0;
        if (s.host_skip) bus_xfer(1'b1, REG_SKIP, 32'h1, rd);
        // over in bit 9, won in 8, stage in 6:4, state in 2:0
        exp_word = {22'd0, s.exp_flags[0], s.exp_flags[1], 1'b0, s.exp_stage,
                    1'b0, s.exp_state};
        wait_for_status(s.name, exp_word);
        check_value({s.name, " enables"}, 32'(s.exp_en),
                    {blocks.en_player, blocks.en_monst, blocks.en_astero, blocks.en_boss});
        check_value({s.name, " resets"}, 32'(s.exp_rst),
                    {blocks.rst_player_n, blocks.rst_monst_n});
        check_value({s.name, " stage"}, 32'(s.exp_stage), 32'(stage_num));
        check_value({s.name, " flags"}, 32'(s.exp_flags), {game_won, game_over});
    endtask

    initial begin
        resetN = 1'b0;
        {start_game, pause, skip_btn, win_stage, player_dead} = '0;
        wb_in = '0;
        // name            lvl     pls    hs    state         stg   en       rst    flg
        add_step("idle",        3'b000, 2'b00, 1'b0, ST_RESET,     3'd0, 4'b0000, 2'b00, 2'b00);
        add_step("start",       3'b100, 2'b00, 1'b0, ST_RUN,       3'd0, 4'b1100, 2'b11, 2'b00);
        add_step("pause",       3'b110, 2'b00, 1'b0, ST_PAUSE,     3'd0, 4'b0000, 2'b11, 2'b00);
        add_step("skip_paused", 3'b110, 2'b01, 1'b0, ST_PAUSE,     3'd0, 4'b0000, 2'b11, 2'b00);
        add_step("resume",      3'b100, 2'b00, 1'b0, ST_RUN,       3'd0, 4'b1100, 2'b11, 2'b00);
        add_step("win_pulse",   3'b100, 2'b10, 1'b0, ST_RUN,       3'd1, 4'b1010, 2'b10, 2'b00);
        add_step("skip_button", 3'b100, 2'b01, 1'b0, ST_RUN,       3'd2, 4'b1001, 2'b10, 2'b00);
        add_step("dead",        3'b101, 2'b00, 1'b0, ST_GAME_OVER, 3'd2, 4'b0000, 2'b10, 2'b01);
        add_step("stop",        3'b000, 2'b00, 1'b0, ST_RESET,     3'd0, 4'b0000, 2'b00, 2'b00);
        add_step("restart",     3'b100, 2'b00, 1'b0, ST_RUN,       3'd0, 4'b1100, 2'b11, 2'b00);
        add_step("host_skip",   3'b100, 2'b00, 1'b1, ST_RUN,       3'd1, 4'b1010, 2'b10, 2'b00);
        add_step("win_to_2",    3'b100, 2'b10, 1'b0, ST_RUN,       3'd2, 4'b1001, 2'b10, 2'b00);
        add_step("win_to_3",    3'b100, 2'b10, 1'b0, ST_RUN,       3'd3, 4'b1100, 2'b11, 2'b00);
        add_step("final_win",   3'b100, 2'b10, 1'b0, ST_GAME_OVER, 3'd3, 4'b0000, 2'b10, 2'b10);
        add_step("back_reset",  3'b000, 2'b00, 1'b0, ST_RESET,     3'd0, 4'b0000, 2'b00, 2'b00);
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetN = 1'b1;
        bus_xfer(1'b0, REG_ID, '0, rd);
        check_value("id_register", WB_ID_VALUE, rd);
        bus_xfer(1'b0, 2'd3, '0, rd);
        check_value("unmapped_read", 32'd0, rd);
        foreach (steps[i]) apply_step(steps[i]);
        $display("summary: %0d checks, %0d mismatches, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wall -Wno-fatal
TOP       = tb_game_ctrl
FLIST     = vlog.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)

/* vlog.f */
src/game_pkg.sv
src/wb_pkg.sv
src/input_conditioner.sv
src/stage_controller.sv
src/game_controller.sv
src/game_status_wb.sv
src/game_ctrl_top.sv
sim/game_ctrl_chk.sv
sim/tb_game_ctrl.sv
